// ==== Makefile ====
TOP = sss_detector_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sss_detector_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sss_detector_top.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/mseq_lfsr.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module mseq_lfsr #(
    // feedback mask, bit k set means x(i+k) feeds x(i+7)
    parameter logic [`LFSR_LEN-1:0] TAPS = 'h11
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic bit_o,
    output logic valid_o
);

    // sreg[k] holds x(i+k), so bit 0 is the oldest bit
    logic [`LFSR_LEN-1:0] sreg;
    logic                 fb;

    // next sequence element from the tapped bits
    assign fb = ^(sreg & TAPS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            // start state x(0..6) = 1,0,0,0,0,0,0
            sreg    <= `LFSR_LEN'(1);
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b1;
            // hold the start state until valid so x(0) is not skipped
            if (valid_o) begin
                sreg <= {fb, sreg[`LFSR_LEN-1:1]};
            end
        end
    end

    assign bit_o = sreg[0];

endmodule

// ==== design/mseq_store.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module mseq_store
    import sss_types_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_ni,
    input  seq_idx_t idx_i,
    input  seq_idx_t m0_i,
    input  seq_idx_t m1_i,
    output logic     ref_bit_o,
    output logic     ready_o
);

    logic              x0_bit, x0_valid;
    logic              x1_bit, x1_valid;
    logic [`SSS_LEN-1:0] seq0, seq1;
    seq_idx_t          wr_cnt;
    logic              wr_en;
    logic [7:0]        sum0, sum1;
    seq_idx_t          pos0, pos1;

    // x0: x(i+7) = x(i+4) xor x(i)
    mseq_lfsr #(.TAPS('h11)) u_lfsr_x0 (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .bit_o   (x0_bit),
        .valid_o (x0_valid)
    );

    // x1: x(i+7) = x(i+1) xor x(i)
    mseq_lfsr #(.TAPS('h03)) u_lfsr_x1 (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .bit_o   (x1_bit),
        .valid_o (x1_valid)
    );

    assign ready_o = (wr_cnt == seq_idx_t'(`SSS_LEN));
    assign wr_en   = x0_valid && x1_valid && !ready_o;

    // write counter, stops at 127 and then stays there
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_cnt <= '0;
        end else if (wr_en) begin
            wr_cnt <= wr_cnt + seq_idx_t'(1);
        end
    end

    // sequence registers
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            seq0[wr_cnt] <= x0_bit;
            seq1[wr_cnt] <= x1_bit;
        end
    end

    // (idx + m) mod 127, one subtract is enough since both are below 127
    assign sum0 = {1'b0, idx_i} + {1'b0, m0_i};
    assign sum1 = {1'b0, idx_i} + {1'b0, m1_i};
    assign pos0 = (sum0 >= 8'(`SSS_LEN)) ? seq_idx_t'(sum0 - 8'(`SSS_LEN)) : seq_idx_t'(sum0);
    assign pos1 = (sum1 >= 8'(`SSS_LEN)) ? seq_idx_t'(sum1 - 8'(`SSS_LEN)) : seq_idx_t'(sum1);

    // sss bit is 1 when both shifted m-sequence bits agree
    assign ref_bit_o = (seq0[pos0] == seq1[pos1]);

endmodule

// ==== design/sss_capture.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module sss_capture
    import sss_types_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     bit_i,
    input  logic     valid_i,
    input  logic     capture_en_i,
    input  logic     restart_i,
    input  seq_idx_t rd_idx_i,
    output logic     rx_bit_o,
    output logic     full_o
);

    logic [`SSS_LEN-1:0] rx_buf;
    seq_idx_t            wr_cnt;
    logic                store;

    // one bit per strobe, only while enabled and room is left
    assign store = valid_i && capture_en_i && !full_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni || restart_i) begin
            wr_cnt <= '0;
            full_o <= 1'b0;
        end else if (store) begin
            wr_cnt <= wr_cnt + seq_idx_t'(1);
            // full on the cycle after the 127th bit
            if (wr_cnt == seq_idx_t'(`SSS_LEN - 1)) begin
                full_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            rx_buf[wr_cnt] <= bit_i;
        end
    end

    // combinational read for the correlator
    assign rx_bit_o = rx_buf[rd_idx_i];

endmodule

// ==== design/sss_correlator.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module sss_correlator
    import sss_types_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  logic    rx_bit_i,
    input  logic    ref_bit_i,
    input  logic    cand_clear_i,
    input  logic    cand_acc_i,
    input  logic    cand_decide_i,
    input  logic    sweep_clear_i,
    input  n_id_1_t n_id_1_i,
    input  n_id_2_t n_id_2_i,
    output n_id_1_t best_n_id_1_o,
    output n_id_t   best_n_id_o
);

    corr_t   count;
    corr_t   max_count;
    n_id_1_t run_n_id_1;
    logic    better;
    n_id_1_t win_n_id_1;
    n_id_t   win_n_id;
    logic    last_cand;

    // strictly greater, so ties keep the lower N_id_1
    assign better     = (count > max_count);
    assign win_n_id_1 = better ? n_id_1_i : run_n_id_1;
    assign last_cand  = (n_id_1_i == n_id_1_t'(`N_ID_1_COUNT - 1));

    // 3 * N_id_1 + N_id_2 as shift plus adds
    assign win_n_id = n_id_t'({win_n_id_1, 1'b0}) + n_id_t'(win_n_id_1) + n_id_t'(n_id_2_i);

    // match counter of the current candidate
    always_ff @(posedge clk_i) begin
        if (!reset_ni || cand_clear_i) begin
            count <= '0;
        end else if (cand_acc_i && (rx_bit_i == ref_bit_i)) begin
            count <= count + corr_t'(1);
        end
    end

    // running maximum over the sweep
    always_ff @(posedge clk_i) begin
        if (!reset_ni || sweep_clear_i) begin
            max_count  <= '0;
            run_n_id_1 <= '0;
        end else if (cand_decide_i && better) begin
            max_count  <= count;
            run_n_id_1 <= n_id_1_i;
        end
    end

    // results only move on the final decide, held until the next sweep ends
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            best_n_id_1_o <= '0;
            best_n_id_o   <= '0;
        end else if (cand_decide_i && last_cand) begin
            best_n_id_1_o <= win_n_id_1;
            best_n_id_o   <= win_n_id;
        end
    end

endmodule

// ==== design/sss_ctrl_pkg.sv ====
package sss_ctrl_pkg;

    // search controller states
    // IDLE waits for the first bit, CAPTURE fills the buffer,
    // SEARCH sweeps all candidates, REPORT is the one result cycle
    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        SEARCH,
        REPORT
    } search_state_t;

endpackage

// ==== design/sss_defines.svh ====
`ifndef SSS_DEFINES_SVH
`define SSS_DEFINES_SVH

// length of one sss sequence and of each m-sequence
`define SSS_LEN 127

// number of cell group identities N_id_1 to sweep
`define N_ID_1_COUNT 336

// m1 runs over this many values before m0 steps by 15
`define SHIFT_PERIOD 112

// register width of the m-sequence generators
`define LFSR_LEN 7

`endif

// ==== design/sss_detector_top.sv ====
`timescale 1ns/1ns

module sss_detector_top
    import sss_types_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  logic    sss_bit_i,
    input  logic    sss_valid_i,
    input  n_id_2_t n_id_2_i,
    input  logic    n_id_2_valid_i,
    output n_id_1_t n_id_1_o,
    output n_id_t   n_id_o,
    output logic    n_id_valid_o
);

    logic     capture_en, restart, full, mseq_ready;
    logic     rx_bit, ref_bit;
    logic     cand_clear, cand_acc, cand_decide, sweep_clear;
    seq_idx_t rd_idx, m0, m1;
    n_id_1_t  cand_n_id_1;
    n_id_2_t  n_id_2;

    sss_search_ctrl u_ctrl (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sss_valid_i   (sss_valid_i),
        .n_id_2_i      (n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .full_i        (full),
        .mseq_ready_i  (mseq_ready),
        .capture_en_o  (capture_en),
        .restart_o     (restart),
        .rd_idx_o      (rd_idx),
        .m0_o          (m0),
        .m1_o          (m1),
        .cand_clear_o  (cand_clear),
        .cand_acc_o    (cand_acc),
        .cand_decide_o (cand_decide),
        .sweep_clear_o (sweep_clear),
        .cand_n_id_1_o (cand_n_id_1),
        .n_id_2_o      (n_id_2),
        .n_id_valid_o  (n_id_valid_o)
    );

    sss_capture u_capture (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .bit_i       (sss_bit_i),
        .valid_i     (sss_valid_i),
        .capture_en_i(capture_en),
        .restart_i   (restart),
        .rd_idx_i    (rd_idx),
        .rx_bit_o    (rx_bit),
        .full_o      (full)
    );

    mseq_store u_mseq (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .idx_i    (rd_idx),
        .m0_i     (m0),
        .m1_i     (m1),
        .ref_bit_o(ref_bit),
        .ready_o  (mseq_ready)
    );

    sss_correlator u_corr (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .rx_bit_i     (rx_bit),
        .ref_bit_i    (ref_bit),
        .cand_clear_i (cand_clear),
        .cand_acc_i   (cand_acc),
        .cand_decide_i(cand_decide),
        .sweep_clear_i(sweep_clear),
        .n_id_1_i     (cand_n_id_1),
        .n_id_2_i     (n_id_2),
        .best_n_id_1_o(n_id_1_o),
        .best_n_id_o  (n_id_o)
    );

endmodule

// ==== design/sss_search_ctrl.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module sss_search_ctrl
    import sss_types_pkg::*;
    import sss_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     sss_valid_i,
    input  n_id_2_t  n_id_2_i,
    input  logic     n_id_2_valid_i,
    input  logic     full_i,
    input  logic     mseq_ready_i,
    output logic     capture_en_o,
    output logic     restart_o,
    output seq_idx_t rd_idx_o,
    output seq_idx_t m0_o,
    output seq_idx_t m1_o,
    output logic     cand_clear_o,
    output logic     cand_acc_o,
    output logic     cand_decide_o,
    output logic     sweep_clear_o,
    output n_id_1_t  cand_n_id_1_o,
    output n_id_2_t  n_id_2_o,
    output logic     n_id_valid_o
);

    // 5 * N_id_2, last entry unused
    localparam seq_idx_t M0_TABLE [4] = '{7'd0, 7'd5, 7'd10, 7'd0};

    search_state_t state_q, state_d;
    logic          deciding;
    logic          start_search;
    logic          last_bit;
    logic          last_cand;
    logic          in_capture;
    seq_idx_t      m0_base;

    assign in_capture   = (state_q == IDLE) || (state_q == CAPTURE);
    assign start_search = (state_q == CAPTURE) && full_i && mseq_ready_i;
    assign last_bit     = (rd_idx_o == seq_idx_t'(`SSS_LEN - 1));
    assign last_cand    = (cand_n_id_1_o == n_id_1_t'(`N_ID_1_COUNT - 1));

    // 127 compare cycles, then one decide cycle per candidate
    assign cand_acc_o    = (state_q == SEARCH) && !deciding;
    assign cand_decide_o = (state_q == SEARCH) && deciding;
    // count is zeroed on the decide edge and before the first candidate
    assign cand_clear_o  = cand_decide_o || start_search;
    assign sweep_clear_o = start_search;
    assign restart_o     = (state_q == REPORT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (sss_valid_i) state_d = CAPTURE;
            CAPTURE: if (start_search) state_d = SEARCH;
            SEARCH:  if (cand_decide_o && last_cand) state_d = REPORT;
            REPORT:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= IDLE;
            capture_en_o <= 1'b0;
            n_id_valid_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            // registered so the enable is low straight out of reset
            capture_en_o <= (state_d == IDLE) || (state_d == CAPTURE);
            // high exactly in the REPORT cycle
            n_id_valid_o <= cand_decide_o && last_cand;
        end
    end

    // sector id latch, last strobe before the search wins
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_2_o <= '0;
            m0_base  <= '0;
        end else if (n_id_2_valid_i && in_capture) begin
            n_id_2_o <= n_id_2_i;
            m0_base  <= M0_TABLE[n_id_2_i];
        end
    end

    // bit index, candidate and cyclic shift counters
    always_ff @(posedge clk_i) begin
        if (!reset_ni || start_search) begin
            deciding      <= 1'b0;
            rd_idx_o      <= '0;
            cand_n_id_1_o <= '0;
            m1_o          <= '0;
            m0_o          <= start_search ? m0_base : seq_idx_t'(0);
        end else if (cand_acc_o) begin
            rd_idx_o <= last_bit ? seq_idx_t'(0) : rd_idx_o + seq_idx_t'(1);
            deciding <= last_bit;
        end else if (cand_decide_o) begin
            deciding <= 1'b0;
            if (!last_cand) begin
                cand_n_id_1_o <= cand_n_id_1_o + n_id_1_t'(1);
                // every 112 candidates m1 wraps and m0 steps by 15
                if (m1_o == seq_idx_t'(`SHIFT_PERIOD - 1)) begin
                    m1_o <= '0;
                    m0_o <= m0_o + seq_idx_t'(15);
                end else begin
                    m1_o <= m1_o + seq_idx_t'(1);
                end
            end
        end
    end

endmodule

// ==== design/sss_types_pkg.sv ====
`include "sss_defines.svh"

package sss_types_pkg;

    // cell group identity, 0 to 335
    typedef logic [8:0] n_id_1_t;

    // sector identity from the pss, 0 to 2
    typedef logic [1:0] n_id_2_t;

    // physical cell identity, 0 to 1007
    typedef logic [9:0] n_id_t;

    // bit index and cyclic shifts m0 / m1, all 0 to 126
    typedef logic [`LFSR_LEN-1:0] seq_idx_t;

    // match count of one candidate, 0 to 127
    typedef logic [7:0] corr_t;

endpackage

// ==== sss_detector_top.f ====
+incdir+design
design/sss_types_pkg.sv
design/sss_ctrl_pkg.sv
design/mseq_lfsr.sv
design/mseq_store.sv
design/sss_capture.sv
design/sss_correlator.sv
design/sss_search_ctrl.sv
design/sss_detector_top.sv
verification/sss_detector_sva.sv
verification/sss_detector_tb.sv

// ==== verification/sss_detector_sva.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module sss_detector_sva
    import sss_ctrl_pkg::*;
(
    input logic          clk_i,
    input logic          reset_ni,
    input search_state_t state_i,
    input logic          capture_en_i,
    input logic          cand_acc_i,
    input logic          cand_decide_i,
    input logic          n_id_valid_i
);

    // length of the current run of compare cycles
    logic [7:0]  acc_run;
    // cycles spent in SEARCH since it was entered
    logic [15:0] search_run;

    always_ff @(posedge clk_i) begin
        if (!reset_ni || !cand_acc_i) begin
            acc_run <= '0;
        end else begin
            acc_run <= acc_run + 8'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni || (state_i != SEARCH)) begin
            search_run <= '0;
        end else begin
            search_run <= search_run + 16'd1;
        end
    end

    // a decide closes exactly 127 compare cycles
    decide_after_acc: assert property (@(posedge clk_i) disable iff (!reset_ni)
        cand_decide_i |-> (acc_run == 8'(`SSS_LEN)))
        else $error("cand_decide after %0d compare cycles", acc_run);

    // no candidate runs past 127 compares
    acc_run_bound: assert property (@(posedge clk_i) disable iff (!reset_ni)
        cand_acc_i |-> (acc_run < 8'(`SSS_LEN)))
        else $error("cand_acc run too long");

    // report pulse is one cycle wide
    valid_one_cycle: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !n_id_valid_i)
        else $error("n_id_valid_o held for more than one cycle");

    // report comes right after 336 candidates of 128 cycles each
    sweep_length: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |-> (search_run == 16'(`N_ID_1_COUNT * (`SSS_LEN + 1))))
        else $error("report after %0d search cycles", search_run);

    // everything quiet once a reset edge has passed
    quiet_after_reset: assert property (@(posedge clk_i)
        !reset_ni |=> !n_id_valid_i && !capture_en_i && !cand_acc_i && !cand_decide_i)
        else $error("controller output active after reset");

endmodule

bind sss_search_ctrl sss_detector_sva u_sva (
    .clk_i        (clk_i),
    .reset_ni     (reset_ni),
    .state_i      (state_q),
    .capture_en_i (capture_en_o),
    .cand_acc_i   (cand_acc_o),
    .cand_decide_i(cand_decide_o),
    .n_id_valid_i (n_id_valid_o)
);

// ==== verification/sss_detector_tb.sv ====
`timescale 1ns/1ns
`include "sss_defines.svh"

module sss_detector_tb
    import sss_types_pkg::*;
();

    localparam int NUM_ROWS    = 9;
    // table rows plus the sector-override and reset tests
    localparam int NUM_TESTS   = NUM_ROWS + 2;
    // one capture plus a full sweep of 43008 cycles fits in this
    localparam int TEST_CYCLES = 45000;
    // a full sweep, 336 candidates of 128 cycles
    localparam int SEARCH_CYCLES = `N_ID_1_COUNT * (`SSS_LEN + 1);
    localparam int CLK_HALF    = 2;

    typedef struct packed {
        n_id_1_t    n_id_1;
        n_id_2_t    n_id_2;
        logic [4:0] flips;
        logic       gaps;
        n_id_1_t    exp_n_id_1;
    } row_t;

    // n_id_1, n_id_2, flipped bits, random gaps, expected n_id_1
    localparam row_t STIM_TABLE [NUM_ROWS] = '{
        '{9'd0,   2'd0, 5'd0,  1'b0, 9'd0},
        '{9'd335, 2'd2, 5'd0,  1'b0, 9'd335},
        '{9'd17,  2'd1, 5'd0,  1'b0, 9'd17},
        '{9'd111, 2'd0, 5'd0,  1'b0, 9'd111},
        '{9'd112, 2'd1, 5'd0,  1'b0, 9'd112},
        '{9'd224, 2'd2, 5'd0,  1'b0, 9'd224},
        '{9'd200, 2'd1, 5'd20, 1'b0, 9'd200},
        '{9'd57,  2'd2, 5'd12, 1'b1, 9'd57},
        '{9'd300, 2'd0, 5'd0,  1'b1, 9'd300}
    };

    logic    clk_i;
    logic    reset_ni;
    logic    sss_bit_i;
    logic    sss_valid_i;
    n_id_2_t n_id_2_i;
    logic    n_id_2_valid_i;
    n_id_1_t n_id_1_o;
    n_id_t   n_id_o;
    logic    n_id_valid_o;

    // model m-sequences x0 and x1
    logic   x0 [`SSS_LEN];
    logic   x1 [`SSS_LEN];
    integer seed;
    int     passed;
    int     failed;
    logic   test_ok;

    sss_detector_top dut (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sss_bit_i     (sss_bit_i),
        .sss_valid_i   (sss_valid_i),
        .n_id_2_i      (n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .n_id_1_o      (n_id_1_o),
        .n_id_o        (n_id_o),
        .n_id_valid_o  (n_id_valid_o)
    );

    always #CLK_HALF clk_i = ~clk_i;

    task automatic build_sequences();
        // both start from 1,0,0,0,0,0,0
        for (int i = 0; i < 7; i++) begin
            x0[i] = (i == 0);
            x1[i] = (i == 0);
        end
        for (int i = 0; i < `SSS_LEN - 7; i++) begin
            x0[i + 7] = x0[i + 4] ^ x0[i];
            x1[i + 7] = x1[i + 1] ^ x1[i];
        end
    endtask

    // sss bit n of one identity pair
    function automatic logic ref_sss_bit(input int nid1, input int nid2, input int n);
        int m0;
        int m1;
        m0 = 15 * (nid1 / `SHIFT_PERIOD) + 5 * nid2;
        m1 = nid1 % `SHIFT_PERIOD;
        return x0[(n + m0) % `SSS_LEN] == x1[(n + m1) % `SSS_LEN];
    endfunction

    task automatic make_burst(input int nid1, input int nid2, input int flips,
                              output logic [`SSS_LEN-1:0] bits);
        int pos;
        for (int n = 0; n < `SSS_LEN; n++) begin
            bits[n] = ref_sss_bit(nid1, nid2, n);
        end
        // a position drawn twice cancels, so this is up to flips errors
        for (int k = 0; k < flips; k++) begin
            pos = int'($unsigned($random(seed)) % `SSS_LEN);
            bits[pos] = ~bits[pos];
        end
    endtask

    // all drive tasks start and end on a falling edge
    task automatic apply_reset();
        reset_ni = 1'b0;
        repeat (3) @(negedge clk_i);
        reset_ni = 1'b1;
        @(negedge clk_i);
    endtask

    task automatic load_n_id_2(input n_id_2_t value);
        n_id_2_i       = value;
        n_id_2_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_2_valid_i = 1'b0;
    endtask

    task automatic send_burst(input logic [`SSS_LEN-1:0] bits, input int first,
                              input int stop, input logic gaps);
        int gap;
        for (int n = first; n < stop; n++) begin
            sss_bit_i   = bits[n];
            sss_valid_i = 1'b1;
            @(negedge clk_i);
            sss_valid_i = 1'b0;
            if (n_id_valid_o) begin
                $display("ERROR: report pulse while capturing bit %0d", n);
                test_ok = 1'b0;
            end
            gap = gaps ? int'($unsigned($random(seed)) % 4) : 0;
            repeat (gap) @(negedge clk_i);
        end
        sss_bit_i = 1'b0;
    endtask

    // no report allowed here, optionally with stray strobes on all inputs
    task automatic expect_quiet(input int cycles, input logic noise);
        for (int c = 0; c < cycles; c++) begin
            n_id_2_i       = n_id_2_t'(c % 3);
            n_id_2_valid_i = noise;
            sss_valid_i    = noise;
            sss_bit_i      = 1'($random(seed));
            @(negedge clk_i);
            if (n_id_valid_o) begin
                $display("ERROR: unexpected report pulse after %0d quiet cycles", c);
                test_ok = 1'b0;
            end
        end
        n_id_2_valid_i = 1'b0;
        sss_valid_i    = 1'b0;
        sss_bit_i      = 1'b0;
    endtask

    task automatic wait_report(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TEST_CYCLES) begin
            @(negedge clk_i);
            seen = n_id_valid_o;
            cycles++;
        end
    endtask

    task automatic check_n_id_1(input n_id_1_t got, input n_id_1_t exp);
        if (got !== exp) begin
            $display("MISMATCH n_id_1_o: got 0x%h, expected 0x%h", got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_n_id(input n_id_t got, input n_id_t exp);
        if (got !== exp) begin
            $display("MISMATCH n_id_o: got 0x%h, expected 0x%h", got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input int id, input int nid1, input int nid2);
        logic seen;
        wait_report(seen);
        if (!seen) begin
            $display("ERROR: test %0d got no report within %0d cycles", id, TEST_CYCLES);
            test_ok = 1'b0;
            apply_reset();
        end else begin
            check_n_id_1(n_id_1_o, n_id_1_t'(nid1));
            check_n_id(n_id_o, n_id_t'(3 * nid1 + nid2));
            // REPORT hands over to IDLE before the next burst
            @(negedge clk_i);
        end
        if (test_ok) begin
            passed++;
            $display("test %0d: n_id_1 %0d n_id_2 %0d ok", id, nid1, nid2);
        end else begin
            failed++;
            $display("test %0d: n_id_1 %0d n_id_2 %0d error", id, nid1, nid2);
        end
    endtask

    // watchdog sized from the number of tests
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk_i);
        $display("ERROR: watchdog expired after %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [`SSS_LEN-1:0] bits;
        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        sss_bit_i      = 1'b0;
        sss_valid_i    = 1'b0;
        n_id_2_i       = '0;
        n_id_2_valid_i = 1'b0;
        seed           = 2;
        passed         = 0;
        failed         = 0;
        build_sequences();
        apply_reset();

        // clean, edge, noisy and gapped bursts from the table
        for (int r = 0; r < NUM_ROWS; r++) begin
            test_ok = 1'b1;
            load_n_id_2(STIM_TABLE[r].n_id_2);
            make_burst(int'(STIM_TABLE[r].n_id_1), int'(STIM_TABLE[r].n_id_2),
                       int'(STIM_TABLE[r].flips), bits);
            send_burst(bits, 0, `SSS_LEN, STIM_TABLE[r].gaps);
            finish_test(r, int'(STIM_TABLE[r].exp_n_id_1), int'(STIM_TABLE[r].n_id_2));
        end

        // second sector strobe replaces the first, strobes during search ignored
        test_ok = 1'b1;
        load_n_id_2(2'd0);
        load_n_id_2(2'd1);
        make_burst(150, 1, 0, bits);
        send_burst(bits, 0, `SSS_LEN, 1'b0);
        // let the controller enter SEARCH first
        expect_quiet(4, 1'b0);
        expect_quiet(300, 1'b1);
        finish_test(NUM_ROWS, 150, 1);

        // reset cuts a burst, then a full new burst is needed
        test_ok = 1'b1;
        load_n_id_2(2'd0);
        make_burst(260, 0, 0, bits);
        send_burst(bits, 0, 60, 1'b0);
        apply_reset();
        load_n_id_2(2'd2);
        make_burst(77, 2, 5, bits);
        send_burst(bits, 0, `SSS_LEN - 1, 1'b1);
        // one bit short of a burst
        expect_quiet(200, 1'b0);
        send_burst(bits, `SSS_LEN - 1, `SSS_LEN, 1'b0);
        // the sweep over this burst has to run in full before any report
        expect_quiet(SEARCH_CYCLES, 1'b0);
        finish_test(NUM_ROWS + 1, 77, 2);

        $display("tests %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
